/* cmo_handler.f */
+incdir+src
src/cmo_pkg.sv
src/cmo_fence_ctrl.sv
src/cmo_inval_ctrl.sv
src/cmo_rsp_ctrl.sv
src/cmo_handler.sv
test/cmo_handler_assertions.sv
test/tb_cmo_handler.sv

/* Bender.yml */
package:
  name: cmo_handler

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cmo_pkg.sv
      - src/cmo_fence_ctrl.sv
      - src/cmo_inval_ctrl.sv
      - src/cmo_rsp_ctrl.sv
      - src/cmo_handler.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/cmo_handler_assertions.sv
      - test/tb_cmo_handler.sv

/* test/tb_cmo_handler.sv */
// Table driven testbench for the CMO handler with a small directory model
`timescale 1ns/1ps
`default_nettype none

`include "cmo_defs.svh"

module tb_cmo_handler
    import cmo_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;

    // One table row, stimulus and the directory answer
    typedef struct packed {
        cmo_op_t      op;
        cmo_addr_t    addr;
        cmo_sid_t     sid;
        cmo_tid_t     tid;
        logic         need_rsp;
        cmo_way_vec_t hit;
        logic [3:0]   delay;
        logic [3:0]   backpressure;
    } row_t;

    logic           clk_i;
    logic           rst_ni;
    logic           req_valid_i;
    cmo_req_t       req_i;
    logic           req_ready_o;
    logic           core_rsp_valid_o;
    cmo_rsp_t       core_rsp_o;
    logic           core_rsp_ready_i;
    logic           wbuf_empty_i, rtab_empty_i, mshr_empty_i, ctrl_empty_i;
    logic           wbuf_flush_all_o;
    logic           req_wait_o;
    logic           dir_check_o;
    cmo_dir_check_t dir_check_data_o;
    cmo_way_vec_t   dir_hit_way_i;
    logic           dir_updt_o;
    cmo_dir_updt_t  dir_updt_data_o;
    logic           inval_all_o;

    row_t        rows[$];
    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          cur_row;
    int          cur_cycle;
    int          cycle_limit = 0;
    int          cycle_cnt;

    cmo_handler i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    task automatic random_bit(output logic b);
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s expected %h got %h (row %0d, cycle %0d)",
                     name, exp, got, cur_row, cur_cycle);
        end
    endtask

    task automatic add_row(input cmo_op_t op, input cmo_addr_t addr, input cmo_sid_t sid,
                           input cmo_tid_t tid, input logic need_rsp, input cmo_way_vec_t hit,
                           input int delay, input int backpressure);
        row_t row;
        row.op           = op;
        row.addr         = addr;
        row.sid          = sid;
        row.tid          = tid;
        row.need_rsp     = need_rsp;
        row.hit          = hit;
        row.delay        = delay[3:0];
        row.backpressure = backpressure[3:0];
        rows.push_back(row);
    endtask

    // Idle cycles between rows, queues empty and nothing may happen
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_i);
            cur_cycle        = i;
            req_valid_i      = 1'b0;
            req_i            = '0;
            wbuf_empty_i     = 1'b1;
            rtab_empty_i     = 1'b1;
            mshr_empty_i     = 1'b1;
            ctrl_empty_i     = 1'b1;
            core_rsp_ready_i = 1'b1;
            dir_hit_way_i    = '0;
            #(CLK_PERIOD / 4);
            check_value("req_ready_o", req_ready_o, 1'b1);
            check_value("core_rsp_valid_o", core_rsp_valid_o, 1'b0);
            check_value("req_wait_o", req_wait_o, 1'b0);
            check_value("wbuf_flush_all_o", wbuf_flush_all_o, 1'b0);
            check_value("dir_check_o", dir_check_o, 1'b0);
            check_value("dir_updt_o", dir_updt_o, 1'b0);
            check_value("inval_all_o", inval_all_o, 1'b0);
        end
    endtask

    // Cycle 0 presents the request, the engines run from cycle 2
    task automatic run_row(input int idx);
        row_t           r;
        cmo_req_t       req;
        cmo_dir_check_t exp_check;
        cmo_dir_updt_t  exp_updt_data;
        int             empty_c, done_c, xfer_c, last_c;
        logic           is_fence, is_line, is_all;
        logic           busy, rnd_a, rnd_b, check_prev, exp_updt, exp_rsp;
        r            = rows[idx];
        is_fence     = (r.op == `CMO_OP_FENCE);
        is_line      = (r.op == `CMO_OP_INVAL_NLINE);
        is_all       = (r.op == `CMO_OP_INVAL_ALL);
        req.op       = r.op;
        req.addr     = r.addr;
        req.sid      = r.sid;
        req.tid      = r.tid;
        req.need_rsp = r.need_rsp;
        exp_check.set = r.addr[`CMO_OFFSET_WIDTH +: `CMO_SET_WIDTH];
        exp_check.tag = r.addr[`CMO_ADDR_WIDTH-1 -: `CMO_TAG_WIDTH];
        empty_c = 2 + int'(r.delay);
        done_c  = is_fence ? empty_c : (is_line ? empty_c + 2 : empty_c + 16);
        xfer_c  = done_c + 1 + int'(r.backpressure);
        last_c  = r.need_rsp ? xfer_c : done_c + 1;
        check_prev = 1'b0;
        for (int c = 0; c <= last_c; c++) begin
            @(negedge clk_i);
            cur_cycle   = c;
            req_valid_i = (c == 0);
            req_i       = (c == 0) ? req : '0;
            random_bit(rnd_a);
            random_bit(rnd_b);
            busy = (c < empty_c);
            // Each status the engine waits for is at times the only one still low
            if (is_fence) begin
                wbuf_empty_i = busy ? rnd_a : 1'b1;
                rtab_empty_i = busy ? (!rnd_a && rnd_b) : 1'b1;
                mshr_empty_i = busy ? rnd_b : 1'b1;
                ctrl_empty_i = busy ? rnd_b : 1'b1;
            end else begin
                wbuf_empty_i = busy ? rnd_a : 1'b1;
                mshr_empty_i = busy ? (rnd_a ^ rnd_b) : 1'b1;
                rtab_empty_i = busy ? !rnd_b : 1'b1;
                ctrl_empty_i = busy ? !rnd_a : 1'b1;
            end
            core_rsp_ready_i = (c >= xfer_c);
            // Directory answers the lookup of the previous cycle
            dir_hit_way_i    = check_prev ? r.hit : '0;
            #(CLK_PERIOD / 4);
            check_prev = dir_check_o;
            check_value("req_ready_o", req_ready_o,
                        (c == 0) || (c > done_c && !(r.need_rsp && c <= xfer_c)));
            check_value("req_wait_o", req_wait_o, c >= 2 && c <= empty_c);
            check_value("wbuf_flush_all_o", wbuf_flush_all_o,
                        is_fence && c >= 2 && c <= empty_c && rtab_empty_i);
            check_value("dir_check_o", dir_check_o, is_line && c == empty_c + 1);
            if (is_line && c == empty_c + 1) begin
                check_value("dir_check_data_o", dir_check_data_o, exp_check);
            end
            exp_updt = (is_line && r.hit != '0 && c == empty_c + 2) ||
                       (is_all && c > empty_c && c <= empty_c + 16);
            check_value("dir_updt_o", dir_updt_o, exp_updt);
            if (exp_updt) begin
                exp_updt_data.set = is_all ? cmo_set_t'(c - empty_c - 1) : exp_check.set;
                exp_updt_data.way = is_all ? {`CMO_WAYS{1'b1}} : r.hit;
                check_value("dir_updt_data_o", dir_updt_data_o, exp_updt_data);
            end
            check_value("inval_all_o", inval_all_o, is_all && c == empty_c + 16);
            exp_rsp = r.need_rsp && c > done_c && c <= xfer_c;
            check_value("core_rsp_valid_o", core_rsp_valid_o, exp_rsp);
            if (exp_rsp) begin
                check_value("core_rsp_o", core_rsp_o, {r.sid, r.tid});
            end
        end
    endtask

    task automatic build_table();
        //      op                   addr          sid   tid    rsp   hit      delay bp
        add_row(`CMO_OP_FENCE,       32'h0000_0000, 2'd1, 4'd3,  1'b1, 4'b0000, 3, 0);
        add_row(`CMO_OP_FENCE,       32'h0000_0000, 2'd0, 4'd1,  1'b0, 4'b0000, 0, 0);
        add_row(`CMO_OP_INVAL_NLINE, 32'h1234_5680, 2'd2, 4'd5,  1'b1, 4'b0100, 2, 2);
        add_row(`CMO_OP_INVAL_NLINE, 32'hDEAD_BEEF, 2'd3, 4'd9,  1'b1, 4'b0000, 1, 0);
        add_row(`CMO_OP_INVAL_ALL,   32'h0000_0000, 2'd0, 4'd12, 1'b1, 4'b0000, 4, 3);
        add_row(`CMO_OP_INVAL_NLINE, 32'h0000_07C0, 2'd1, 4'd7,  1'b0, 4'b1001, 0, 0);
        add_row(`CMO_OP_FENCE,       32'h0000_0000, 2'd2, 4'd14, 1'b1, 4'b0000, 5, 4);
        add_row(`CMO_OP_INVAL_ALL,   32'h0000_0000, 2'd3, 4'd2,  1'b0, 4'b0000, 0, 0);
        add_row(`CMO_OP_INVAL_NLINE, 32'hFFFF_FFC0, 2'd1, 4'd15, 1'b1, 4'b0001, 3, 1);
    endtask

    initial begin
        int   max_wait;
        logic gap_a, gap_b;
        lfsr_q           = 16'd73;
        errors           = 0;
        checks           = 0;
        cur_row          = -1;
        cur_cycle        = 0;
        rst_ni           = 1'b0;
        req_valid_i      = 1'b0;
        req_i            = '0;
        core_rsp_ready_i = 1'b0;
        wbuf_empty_i     = 1'b1;
        rtab_empty_i     = 1'b1;
        mshr_empty_i     = 1'b1;
        ctrl_empty_i     = 1'b1;
        dir_hit_way_i    = '0;
        build_table();
        max_wait = 0;
        foreach (rows[i]) begin
            if (int'(rows[i].delay) + int'(rows[i].backpressure) > max_wait) begin
                max_wait = int'(rows[i].delay) + int'(rows[i].backpressure);
            end
        end
        cycle_limit = RESET_CYCLES + 10 + rows.size() * (16 + max_wait + 10);
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        idle_cycles(2);
        for (int i = 0; i < rows.size(); i++) begin
            cur_row = i;
            random_bit(gap_a);
            random_bit(gap_b);
            idle_cycles({gap_a, gap_b});
            run_row(i);
        end
        idle_cycles(2);
        errors += i_dut.i_assertions.fail_count;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog on the clock
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout, the table did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* test/cmo_handler_assertions.sv */
// Protocol assertions for the CMO handler response and directory updates
`timescale 1ns/1ps
`default_nettype none

module cmo_handler_assertions
    import cmo_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_ready_o,
    input  logic     core_rsp_valid_o,
    input  cmo_rsp_t core_rsp_o,
    input  logic     core_rsp_ready_i,
    input  logic     dir_updt_o,
    input  logic     req_wait_o
);

    int unsigned fail_count = 0;

    // No new request while a response is pending
    ready_low_during_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o |-> !req_ready_o)
    else begin
        fail_count++;
        $error("req_ready_o is high while a core response is pending");
    end

    // Response holds under back-pressure
    rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o && !core_rsp_ready_i |=> core_rsp_valid_o && $stable(core_rsp_o))
    else begin
        fail_count++;
        $error("core response changed before it was taken");
    end

    // Directory stays untouched while the cache settles
    no_updt_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(dir_updt_o) |-> !req_wait_o)
    else begin
        fail_count++;
        $error("dir_updt_o rose while req_wait_o was high");
    end

endmodule

bind cmo_handler cmo_handler_assertions i_assertions (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_ready_o      (req_ready_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_o       (core_rsp_o),
    .core_rsp_ready_i (core_rsp_ready_i),
    .dir_updt_o       (dir_updt_o),
    .req_wait_o       (req_wait_o)
);

`default_nettype wire

/* src/cmo_handler.sv */
// CMO handler top level with fence and invalidation engines
`timescale 1ns/1ps
`default_nettype none

module cmo_handler
    import cmo_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    // Core request
    input  logic           req_valid_i,
    input  cmo_req_t       req_i,
    output logic           req_ready_o,

    // Core response
    output logic           core_rsp_valid_o,
    output cmo_rsp_t       core_rsp_o,
    input  logic           core_rsp_ready_i,

    // Cache status levels
    input  logic           wbuf_empty_i,
    input  logic           rtab_empty_i,
    input  logic           mshr_empty_i,
    input  logic           ctrl_empty_i,

    output logic           wbuf_flush_all_o,
    output logic           req_wait_o,

    // Directory access
    output logic           dir_check_o,
    output cmo_dir_check_t dir_check_data_o,
    input  cmo_way_vec_t   dir_hit_way_i,
    output logic           dir_updt_o,
    output cmo_dir_updt_t  dir_updt_data_o,

    output logic           inval_all_o
);

    logic      start;
    cmo_op_t   op;
    cmo_addr_t addr;
    logic      fence_done;
    logic      inval_done;
    logic      fence_wait;
    logic      inval_wait;

    cmo_rsp_ctrl i_rsp_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .start_o          (start),
        .op_o             (op),
        .addr_o           (addr),
        .fence_done_i     (fence_done),
        .inval_done_i     (inval_done),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .core_rsp_ready_i (core_rsp_ready_i)
    );

    cmo_fence_ctrl i_fence_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .start_i          (start),
        .op_i             (op),
        .wbuf_empty_i     (wbuf_empty_i),
        .rtab_empty_i     (rtab_empty_i),
        .wbuf_flush_all_o (wbuf_flush_all_o),
        .wait_o           (fence_wait),
        .done_o           (fence_done)
    );

    cmo_inval_ctrl i_inval_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .start_i          (start),
        .op_i             (op),
        .addr_i           (addr),
        .mshr_empty_i     (mshr_empty_i),
        .rtab_empty_i     (rtab_empty_i),
        .ctrl_empty_i     (ctrl_empty_i),
        .dir_check_o      (dir_check_o),
        .dir_check_data_o (dir_check_data_o),
        .dir_hit_way_i    (dir_hit_way_i),
        .dir_updt_o       (dir_updt_o),
        .dir_updt_data_o  (dir_updt_data_o),
        .inval_all_o      (inval_all_o),
        .wait_o           (inval_wait),
        .done_o           (inval_done)
    );

    // Core stalls while either engine waits for the cache to settle
    assign req_wait_o = fence_wait | inval_wait;

endmodule

`default_nettype wire

/* src/cmo_rsp_ctrl.sv */
// Request acceptance, in-flight tracking and core response buffer
`timescale 1ns/1ps
`default_nettype none

module cmo_rsp_ctrl
    import cmo_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Core request
    input  logic      req_valid_i,
    input  cmo_req_t  req_i,
    output logic      req_ready_o,

    // Registered request towards the engines
    output logic      start_o,
    output cmo_op_t   op_o,
    output cmo_addr_t addr_o,

    // Engine completions
    input  logic      fence_done_i,
    input  logic      inval_done_i,

    // Core response
    output logic      core_rsp_valid_o,
    output cmo_rsp_t  core_rsp_o,
    input  logic      core_rsp_ready_i
);

    logic      busy_q;
    logic      rsp_valid_q;
    logic      need_rsp_q;
    logic      start_q;
    cmo_op_t   op_q;
    cmo_addr_t addr_q;
    cmo_rsp_t  rsp_q;

    logic      accept;
    logic      op_done;
    logic      rsp_taken;

    // One operation at a time, and only once the last response is gone
    assign req_ready_o = ~busy_q & ~rsp_valid_q;
    assign accept      = req_valid_i & req_ready_o;
    assign op_done     = fence_done_i | inval_done_i;
    assign rsp_taken   = rsp_valid_q & core_rsp_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            need_rsp_q  <= 1'b0;
            start_q     <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                busy_q     <= 1'b1;
                need_rsp_q <= req_i.need_rsp;
            end else if (op_done) begin
                busy_q <= 1'b0;
            end
            if (op_done) begin
                rsp_valid_q <= need_rsp_q;
            end else if (rsp_taken) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    // Request payload, held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q      <= req_i.op;
            addr_q    <= req_i.addr;
            rsp_q.sid <= req_i.sid;
            rsp_q.tid <= req_i.tid;
        end
    end

    assign start_o          = start_q;
    assign op_o             = op_q;
    assign addr_o           = addr_q;
    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_o       = rsp_q;

endmodule

`default_nettype wire

/* src/cmo_inval_ctrl.sv */
// Invalidation engine for line invalidation and the full set sweep
`timescale 1ns/1ps
`default_nettype none

`include "cmo_defs.svh"

module cmo_inval_ctrl
    import cmo_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    // Accepted request from the response controller
    input  logic           start_i,
    input  cmo_op_t        op_i,
    input  cmo_addr_t      addr_i,

    // Pipeline status
    input  logic           mshr_empty_i,
    input  logic           rtab_empty_i,
    input  logic           ctrl_empty_i,

    // Directory lookup, answered one cycle later
    output logic           dir_check_o,
    output cmo_dir_check_t dir_check_data_o,
    input  cmo_way_vec_t   dir_hit_way_i,

    // Directory invalidation
    output logic           dir_updt_o,
    output cmo_dir_updt_t  dir_updt_data_o,

    output logic           inval_all_o,
    output logic           wait_o,
    output logic           done_o
);

    typedef enum logic [2:0] {
        INVAL_IDLE,
        INVAL_QUIESCE,
        INVAL_CHECK,
        INVAL_CLEAR,
        INVAL_SWEEP
    } inval_state_e;

    inval_state_e state_q, state_d;

    cmo_set_t     line_set;
    cmo_tag_t     line_tag;
    cmo_set_t     sweep_set_q, sweep_set_d;
    logic         sweep_last;
    logic         is_inval_op;
    logic         quiet;

    // Line address split
    assign line_set = addr_i[`CMO_OFFSET_WIDTH +: `CMO_SET_WIDTH];
    assign line_tag = addr_i[`CMO_OFFSET_WIDTH + `CMO_SET_WIDTH +: `CMO_TAG_WIDTH];

    assign is_inval_op = (op_i == `CMO_OP_INVAL_NLINE) || (op_i == `CMO_OP_INVAL_ALL);
    assign quiet       = mshr_empty_i & rtab_empty_i & ctrl_empty_i;
    assign sweep_last  = (sweep_set_q == {`CMO_SET_WIDTH{1'b1}});

    assign dir_check_data_o.set = line_set;
    assign dir_check_data_o.tag = line_tag;

    always_comb begin
        state_d         = state_q;
        sweep_set_d     = sweep_set_q;
        dir_check_o     = 1'b0;
        dir_updt_o      = 1'b0;
        dir_updt_data_o = '0;
        inval_all_o     = 1'b0;
        wait_o          = 1'b0;
        done_o          = 1'b0;

        unique case (state_q)
            INVAL_IDLE: begin
                if (start_i && is_inval_op) begin
                    state_d = INVAL_QUIESCE;
                end
            end
            INVAL_QUIESCE: begin
                // No miss, replay or pipeline access may touch the directory meanwhile
                wait_o = 1'b1;
                if (quiet) begin
                    if (op_i == `CMO_OP_INVAL_ALL) begin
                        sweep_set_d = '0;
                        state_d     = INVAL_SWEEP;
                    end else begin
                        state_d = INVAL_CHECK;
                    end
                end
            end
            INVAL_CHECK: begin
                dir_check_o = 1'b1;
                state_d     = INVAL_CLEAR;
            end
            INVAL_CLEAR: begin
                // Clear only the hit way, a miss leaves the directory alone
                dir_updt_o          = |dir_hit_way_i;
                dir_updt_data_o.set = line_set;
                dir_updt_data_o.way = dir_hit_way_i;
                done_o              = 1'b1;
                state_d             = INVAL_IDLE;
            end
            INVAL_SWEEP: begin
                dir_updt_o          = 1'b1;
                dir_updt_data_o.set = sweep_set_q;
                dir_updt_data_o.way = {`CMO_WAYS{1'b1}};
                sweep_set_d         = sweep_set_q + 1'b1;
                if (sweep_last) begin
                    inval_all_o = 1'b1;
                    done_o      = 1'b1;
                    state_d     = INVAL_IDLE;
                end
            end
            default: begin
                state_d = INVAL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= INVAL_IDLE;
            sweep_set_q <= '0;
        end else begin
            state_q     <= state_d;
            sweep_set_q <= sweep_set_d;
        end
    end

endmodule

`default_nettype wire

/* src/cmo_fence_ctrl.sv */
// Fence engine that drains the write buffer and waits for the queues to empty
`timescale 1ns/1ps
`default_nettype none

`include "cmo_defs.svh"

module cmo_fence_ctrl
    import cmo_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,

    // Accepted request from the response controller
    input  logic    start_i,
    input  cmo_op_t op_i,

    // Queue status
    input  logic    wbuf_empty_i,
    input  logic    rtab_empty_i,

    // Write buffer drain request
    output logic    wbuf_flush_all_o,

    output logic    wait_o,
    output logic    done_o
);

    typedef enum logic {
        FENCE_IDLE,
        FENCE_DRAIN
    } fence_state_e;

    fence_state_e state_q, state_d;
    logic         queues_empty;

    assign queues_empty = wbuf_empty_i & rtab_empty_i;

    always_comb begin
        state_d          = state_q;
        wbuf_flush_all_o = 1'b0;
        wait_o           = 1'b0;
        done_o           = 1'b0;

        unique case (state_q)
            FENCE_IDLE: begin
                if (start_i && (op_i == `CMO_OP_FENCE)) begin
                    state_d = FENCE_DRAIN;
                end
            end
            FENCE_DRAIN: begin
                wait_o = 1'b1;
                // Open write buffer entries only go out once replays are done
                wbuf_flush_all_o = rtab_empty_i;
                if (queues_empty) begin
                    done_o  = 1'b1;
                    state_d = FENCE_IDLE;
                end
            end
            default: begin
                state_d = FENCE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FENCE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* src/cmo_pkg.sv */
// CMO handler shared types for requests, responses and directory access
`default_nettype none

`include "cmo_defs.svh"

package cmo_pkg;

    // Plain vectors with a meaning
    typedef logic [`CMO_ADDR_WIDTH-1:0] cmo_addr_t;
    typedef logic [`CMO_SET_WIDTH-1:0]  cmo_set_t;
    typedef logic [`CMO_TAG_WIDTH-1:0]  cmo_tag_t;
    typedef logic [`CMO_WAYS-1:0]       cmo_way_vec_t;
    typedef logic [`CMO_SID_WIDTH-1:0]  cmo_sid_t;
    typedef logic [`CMO_TID_WIDTH-1:0]  cmo_tid_t;
    typedef logic [`CMO_OP_WIDTH-1:0]   cmo_op_t;

    // Core request, 41 bits
    typedef struct packed {
        cmo_op_t   op;
        cmo_addr_t addr;
        cmo_sid_t  sid;
        cmo_tid_t  tid;
        logic      need_rsp;
    } cmo_req_t;

    // Core response, ids of the completed request
    typedef struct packed {
        cmo_sid_t sid;
        cmo_tid_t tid;
    } cmo_rsp_t;

    // Directory lookup by cache line
    typedef struct packed {
        cmo_set_t set;
        cmo_tag_t tag;
    } cmo_dir_check_t;

    // Directory update, the selected ways are written invalid
    typedef struct packed {
        cmo_set_t     set;
        cmo_way_vec_t way;
    } cmo_dir_updt_t;

endpackage

`default_nettype wire

/* src/cmo_defs.svh */
// CMO handler widths, way count and operation codes
`ifndef CMO_DEFS_SVH
`define CMO_DEFS_SVH

// Byte address and its split into offset, set and tag
`define CMO_ADDR_WIDTH   32
`define CMO_OFFSET_WIDTH 6
`define CMO_SET_WIDTH    4
`define CMO_TAG_WIDTH    (`CMO_ADDR_WIDTH - `CMO_OFFSET_WIDTH - `CMO_SET_WIDTH)

// Associativity of the data cache
`define CMO_WAYS 4

// Request ids, echoed back in the response
`define CMO_SID_WIDTH 2
`define CMO_TID_WIDTH 4

// Operation code width
`define CMO_OP_WIDTH 2

// Operation codes
`define CMO_OP_FENCE       2'd0
`define CMO_OP_INVAL_NLINE 2'd1
`define CMO_OP_INVAL_ALL   2'd2

`endif
